//--- core_pkg.sv
// Machine resources of the scalar sequencer core.
// Data width, register count, memory depth and the types built on them.

package core_pkg;

	localparam int DATA_W     = 16;
	localparam int REG_COUNT  = 16;
	localparam int IMEM_DEPTH = 256;

	typedef logic [DATA_W-1:0] data_t;

	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

	// Program counter, one entry per instruction memory word
	typedef logic [$clog2(IMEM_DEPTH)-1:0] pc_t;

	// Flags from the last result written back
	typedef struct packed {
		logic zero;
		logic negative;
	} status_t;

endpackage

//--- execute_unit.sv
// Execute stage of the scalar sequencer core.
// Works on the issue register directly: ALU and write-back, status flags,
// jump and branch decision, vector dispatch and termination. Every output
// pulse belongs to the cycle in which the instruction sits in this stage.

`timescale 1ns/1ps

module execute_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  run,
	issue_if.sink                 issue,
	output logic                  flush,
	output core_pkg::pc_t         redirect_pc,
	output logic                  halt,
	output logic                  wb_valid,
	output core_pkg::reg_idx_t    wb_index,
	output core_pkg::data_t       wb_data,
	output logic                  vec_valid,
	output isa_pkg::instr_word_t  vec_word,
	output core_pkg::data_t       vec_data,
	output core_pkg::status_t     status,
	output logic                  term
);
	import core_pkg::*;
	import isa_pkg::*;

	instr_word_t    word;
	logic           active;
	logic           is_vec;
	logic           alu_write;
	data_t          alu_result;
	reg_idx_t       dst;
	logic           flow_taken;
	status_t        status_q;

	assign word   = issue.instr;
	assign active = issue.valid && run;
	// Unit select bit
	assign is_vec = word.alu.opcode[OPCODE_W-1];

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		alu_result = '0;
		alu_write  = 1'b0;
		dst        = word.alu.dst;
		case (word.alu.opcode)
			ADD: begin
				alu_result = issue.operand_a + issue.operand_b;
				alu_write  = 1'b1;
			end
			SUB: begin
				alu_result = issue.operand_a - issue.operand_b;
				alu_write  = 1'b1;
			end
			AND: begin
				alu_result = issue.operand_a & issue.operand_b;
				alu_write  = 1'b1;
			end
			OR: begin
				alu_result = issue.operand_a | issue.operand_b;
				alu_write  = 1'b1;
			end
			LDI: begin
				// Immediate view of the same word
				alu_result = data_t'(word.imm.imm);
				alu_write  = 1'b1;
			end
			default: begin
				alu_write = 1'b0;
			end
		endcase
	end

	assign wb_valid = active && alu_write;
	assign wb_index = dst;
	assign wb_data  = alu_result;

	// Flags follow every result written back
	always_ff @(posedge clock) begin
		if (reset) begin
			status_q <= '0;
		end else if (wb_valid) begin
			status_q.zero     <= (alu_result == '0);
			status_q.negative <= alu_result[DATA_W-1];
		end
	end

	assign status = status_q;

	////////////////////////////////////////////////////////////////////////////
	// Jump, branch and termination
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (word.imm.field)
			FLOW_JUMP: flow_taken = 1'b1;
			FLOW_ZERO: flow_taken = status_q.zero;
			FLOW_NEG:  flow_taken = status_q.negative;
			default:   flow_taken = 1'b0;
		endcase
	end

	assign term        = active && word.alu.opcode == TERM;
	assign halt        = term;
	assign flush       = term || (active && word.alu.opcode == FLOW && flow_taken);
	assign redirect_pc = word.imm.imm;

	// Vector dispatch as a plain pulse
	assign vec_valid = active && is_vec;
	assign vec_word  = word;
	assign vec_data  = issue.operand_a;

	a_flush_vec_exclusive: assert property (
		@(posedge clock) disable iff (reset)
		!(flush && vec_valid)
	);

	// The flush on TERM must empty the issue slot behind it
	a_term_single: assert property (
		@(posedge clock) disable iff (reset)
		term |=> !term
	);

endmodule

//--- fetch_unit.sv
// Fetch stage of the scalar sequencer core.
// Owns the instruction memory and its load counter, the program counter
// and the halted flag. The word at the PC is read synchronously into the
// fetch register, one cycle after the PC is presented.

`timescale 1ns/1ps

module fetch_unit (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  load_valid,
	input  isa_pkg::instr_word_t  load_word,
	input  logic                  start,
	input  logic                  run,
	input  logic                  flush,
	input  core_pkg::pc_t         redirect_pc,
	input  logic                  halt,
	fetch_if.source               fetch
);
	import core_pkg::*;
	import isa_pkg::*;

	instr_word_t    imem [IMEM_DEPTH];
	pc_t            load_addr;
	pc_t            pc;
	logic           halted;

	////////////////////////////////////////////////////////////////////////////
	// Program loading
	////////////////////////////////////////////////////////////////////////////

	// Cleared by start so the next program loads from address 0
	always_ff @(posedge clock) begin
		if (reset || start) begin
			load_addr <= '0;
		end else if (load_valid && halted) begin
			load_addr <= load_addr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load_valid && halted) begin
			imem[load_addr] <= load_word;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Program counter and halt
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			pc     <= '0;
			halted <= 1'b1;
		end else if (start) begin
			pc     <= '0;
			halted <= 1'b0;
		end else if (run) begin
			if (halt) begin
				halted <= 1'b1;
			end
			// Taken jump or branch wins over the increment
			if (flush) begin
				pc <= redirect_pc;
			end else if (!halted) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// Fetch register
	always_ff @(posedge clock) begin
		if (reset || start) begin
			fetch.valid <= 1'b0;
		end else if (!fetch.stall) begin
			fetch.valid <= !halted && !flush;
		end
	end

	always_ff @(posedge clock) begin
		if (!fetch.stall) begin
			fetch.instr <= imem[pc];
			fetch.pc    <= pc;
		end
	end

	// The program may only be rewritten while the core stands still
	a_load_while_halted: assert property (
		@(posedge clock) disable iff (reset)
		load_valid |-> halted
	);

endmodule

//--- isa_pkg.sv
// Instruction encoding for the scalar sequencer core.
// Holds the opcode list, the field widths and the 16-bit instruction word,
// which is decoded either as a register format or as an immediate format.

package isa_pkg;

	localparam int OPCODE_W  = 4;
	localparam int REG_IDX_W = 4;
	localparam int IMM_W     = 8;

	// Bit 3 of the opcode selects the vector unit for codes 8 to 15
	typedef enum logic [OPCODE_W-1:0] {
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		LDI  = 4'd5,
		FLOW = 4'd6,
		TERM = 4'd7
	} opcode_t;

	// Condition codes in the field of a FLOW word
	localparam logic [REG_IDX_W-1:0] FLOW_JUMP = 4'd0;
	localparam logic [REG_IDX_W-1:0] FLOW_ZERO = 4'd1;
	localparam logic [REG_IDX_W-1:0] FLOW_NEG  = 4'd2;

	typedef struct packed {
		opcode_t                opcode;
		logic [REG_IDX_W-1:0]   dst;
		logic [REG_IDX_W-1:0]   src_a;
		logic [REG_IDX_W-1:0]   src_b;
	} alu_fmt_t;

	// Field is the destination for LDI and the condition for FLOW
	typedef struct packed {
		opcode_t                opcode;
		logic [REG_IDX_W-1:0]   field;
		logic [IMM_W-1:0]       imm;
	} imm_fmt_t;

	typedef union packed {
		alu_fmt_t   alu;
		imm_fmt_t   imm;
	} instr_word_t;

endpackage

//--- operand_read.sv
// Operand read stage of the scalar sequencer core.
// Decodes the fetched word, reads both sources from the register file
// and substitutes the execute stage's write-back on a match. The result
// is registered into the issue bus one cycle after the fetch register.

`timescale 1ns/1ps

module operand_read (
	input  logic                clock,
	input  logic                reset,
	input  logic                run,
	input  logic                flush,
	input  logic                wb_valid,
	input  core_pkg::reg_idx_t  wb_index,
	input  core_pkg::data_t     wb_data,
	fetch_if.sink               fetch,
	issue_if.source             issue
);
	import core_pkg::*;

	data_t      reg_file [REG_COUNT];
	reg_idx_t   src_a;
	reg_idx_t   src_b;
	data_t      read_a;
	data_t      read_b;

	// Whole pipeline freezes together
	assign fetch.stall = !run;

	////////////////////////////////////////////////////////////////////////////
	// Register file and bypass
	////////////////////////////////////////////////////////////////////////////
	assign src_a = fetch.instr.alu.src_a;
	assign src_b = fetch.instr.alu.src_b;

	always_ff @(posedge clock) begin
		if (wb_valid) begin
			reg_file[wb_index] <= wb_data;
		end
	end

	// Result of the instruction one ahead is not in the file yet
	always_comb begin
		if (wb_valid && wb_index == src_a) begin
			read_a = wb_data;
		end else begin
			read_a = reg_file[src_a];
		end

		if (wb_valid && wb_index == src_b) begin
			read_b = wb_data;
		end else begin
			read_b = reg_file[src_b];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Issue register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			issue.valid <= 1'b0;
		end else if (run) begin
			issue.valid <= fetch.valid && !flush;
		end
	end

	always_ff @(posedge clock) begin
		if (run) begin
			issue.instr     <= fetch.instr;
			issue.operand_a <= read_a;
			issue.operand_b <= read_b;
		end
	end

	// Both younger slots are dropped on a taken jump, branch or TERM
	a_no_issue_after_flush: assert property (
		@(posedge clock) disable iff (reset)
		flush |=> !issue.valid
	);

	// Without a redirect, consecutive valid fetches come from consecutive PCs
	a_fetch_in_order: assert property (
		@(posedge clock) disable iff (reset)
		(run && fetch.valid && !flush) |=>
			(!fetch.valid || fetch.pc == pc_t'($past(fetch.pc) + 1'b1))
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the scalar core testbench with Verilator
set -e

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_scalar_core
./obj_dir/Vtb_scalar_core | tee sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
grep -q "TEST PASS" sim.log
echo "Simulation passed"

//--- scalar_core.sv
// Top level of the scalar sequencer core.
// Connects fetch, operand read and execute. Programs are loaded through
// load_valid and load_word while halted, a start pulse runs them from
// address 0, and run freezes the whole pipeline when low.

`timescale 1ns/1ps

module scalar_core (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  load_valid,
	input  isa_pkg::instr_word_t  load_word,
	input  logic                  start,
	input  logic                  run,
	output logic                  vec_valid,
	output isa_pkg::instr_word_t  vec_word,
	output core_pkg::data_t       vec_data,
	output core_pkg::status_t     status,
	output logic                  term
);
	import core_pkg::*;

	logic       flush;
	pc_t        redirect_pc;
	logic       halt;
	logic       wb_valid;
	reg_idx_t   wb_index;
	data_t      wb_data;

	fetch_if fetch_bus ();
	issue_if issue_bus ();

	fetch_unit fetch_i (
		.clock       (clock),
		.reset       (reset),
		.load_valid  (load_valid),
		.load_word   (load_word),
		.start       (start),
		.run         (run),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.halt        (halt),
		.fetch       (fetch_bus.source)
	);

	operand_read operand_i (
		.clock    (clock),
		.reset    (reset),
		.run      (run),
		.flush    (flush),
		.wb_valid (wb_valid),
		.wb_index (wb_index),
		.wb_data  (wb_data),
		.fetch    (fetch_bus.sink),
		.issue    (issue_bus.source)
	);

	execute_unit execute_i (
		.clock       (clock),
		.reset       (reset),
		.run         (run),
		.issue       (issue_bus.sink),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.halt        (halt),
		.wb_valid    (wb_valid),
		.wb_index    (wb_index),
		.wb_data     (wb_data),
		.vec_valid   (vec_valid),
		.vec_word    (vec_word),
		.vec_data    (vec_data),
		.status      (status),
		.term        (term)
	);

endmodule

//--- stage_if.sv
// Stage-to-stage buses of the scalar sequencer core.
// fetch_if runs from fetch to operand read, issue_if from operand read
// to execute. Neither uses a handshake; data moves whenever run is high.

`timescale 1ns/1ps

////////////////////////////////////////////////////////////////////////////
// Fetch register to operand read
////////////////////////////////////////////////////////////////////////////
interface fetch_if;
	import core_pkg::*;
	import isa_pkg::*;

	logic           valid;
	pc_t            pc;
	instr_word_t    instr;
	// High while the pipeline is frozen
	logic           stall;

	modport source (output valid, pc, instr, input stall);
	modport sink   (input valid, pc, instr, output stall);
endinterface

////////////////////////////////////////////////////////////////////////////
// Issue register to execute
////////////////////////////////////////////////////////////////////////////
interface issue_if;
	import core_pkg::*;
	import isa_pkg::*;

	logic           valid;
	instr_word_t    instr;
	data_t          operand_a;
	data_t          operand_b;

	modport source (output valid, instr, operand_a, operand_b);
	modport sink   (input valid, instr, operand_a, operand_b);
endinterface

//--- tb_isa_model.svh
// Reference model of the scalar ISA, included in the testbench module.
// Runs the program image in order, one instruction at a time, and fills
// the queues of expected vector emissions and the expected final flags.
// Registers and flags carry over from one program to the next, as in the core.

`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

data_t      model_regs [REG_COUNT] = '{default: '0};
status_t    model_flags = '0;

task automatic predict_program();
	instr_word_t    w;
	int             pc;
	int             steps;
	data_t          a;
	data_t          b;
	data_t          result;
	reg_idx_t       dst;
	logic           taken;
	logic           done;

	pc = 0;
	steps = 0;
	done = 1'b0;
	exp_words.delete();
	exp_data.delete();
	while (!done && steps < IMEM_DEPTH) begin
		w = prog[pc];
		steps++;
		pc++;
		if (w.alu.opcode[OPCODE_W-1]) begin
			// Vector command leaves with its first source register
			exp_words.push_back(w);
			exp_data.push_back(model_regs[w.alu.src_a]);
		end else if (w.alu.opcode == TERM) begin
			done = 1'b1;
		end else if (w.alu.opcode == FLOW) begin
			taken = (w.imm.field == FLOW_JUMP)
				|| (w.imm.field == FLOW_ZERO && model_flags.zero)
				|| (w.imm.field == FLOW_NEG && model_flags.negative);
			if (taken) begin
				pc = w.imm.imm;
			end
		end else if (w.alu.opcode != NOP) begin
			a = model_regs[w.alu.src_a];
			b = model_regs[w.alu.src_b];
			dst = w.alu.dst;
			case (w.alu.opcode)
				ADD: result = a + b;
				SUB: result = a - b;
				AND: result = a & b;
				OR:  result = a | b;
				default: begin
					// LDI puts the zero-extended immediate into the field register
					result = data_t'(w.imm.imm);
					dst = w.imm.field;
				end
			endcase
			model_regs[dst] = result;
			model_flags.zero = (result == '0);
			model_flags.negative = result[DATA_W-1];
		end
	end
	exp_status = model_flags;
endtask

`endif

//--- tb_scalar_core.sv
// Testbench for the scalar sequencer core.
// Loads fixed programs, predicts their emissions and final flags with the
// reference model, then runs them with run held high or toggled at random.
// Concurrent assertions compare the DUT against the prediction.

`timescale 1ns/1ps

module tb_scalar_core;
	import core_pkg::*;
	import isa_pkg::*;

	// Four runs of at most 20 instructions each, well under 100 cycles
	// apiece even with run low a quarter of the time
	localparam int TIMEOUT_CYCLES = 4000;

	logic           clock;
	logic           reset;
	logic           load_valid;
	instr_word_t    load_word;
	logic           start;
	logic           run;
	logic           vec_valid;
	instr_word_t    vec_word;
	data_t          vec_data;
	status_t        status;
	logic           term;

	integer         seed = 32'ha6c8;
	int             cycles = 0;
	int             value_errors = 0;
	int             other_errors = 0;
	int             term_count = 0;
	int             term_base = 0;
	logic           started = 1'b0;
	logic           vec_seen = 1'b0;
	logic [15:0]    arith [$];
	logic [15:0]    flow [$];
	logic [15:0]    prog [$];
	instr_word_t    exp_words [$];
	data_t          exp_data [$];
	status_t        exp_status;
	logic           head_present = 1'b0;
	instr_word_t    head_word;
	data_t          head_data;

	`include "tb_isa_model.svh"

	scalar_core dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		vec_seen <= vec_valid;
		if (term) begin
			term_count <= term_count + 1;
		end
	end

	// Step to the next expected emission once one has gone out
	always @(negedge clock) begin
		if (vec_seen && exp_words.size() > 0) begin
			void'(exp_words.pop_front());
			void'(exp_data.pop_front());
		end
		head_present = exp_words.size() > 0;
		if (head_present) begin
			head_word = exp_words[0];
			head_data = exp_data[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////
	a_idle_before_start: assert property (@(posedge clock) disable iff (reset)
		!started |-> (!vec_valid && !term && status == '0)) else begin
		other_errors++;
		$display("Output activity at %0t before the first start", $time);
	end

	a_emission_expected: assert property (@(posedge clock) disable iff (reset)
		vec_valid |-> head_present) else begin
		other_errors++;
		$display("Vector emission at %0t that the model does not predict", $time);
	end

	a_vec_word: assert property (@(posedge clock) disable iff (reset)
		(vec_valid && head_present) |-> vec_word == head_word) else begin
		value_errors++;
		$display("FAILED %0t vec_word got %h expected %h", $time,
			$sampled(vec_word), $sampled(head_word));
	end

	a_vec_data: assert property (@(posedge clock) disable iff (reset)
		(vec_valid && head_present) |-> vec_data == head_data) else begin
		value_errors++;
		$display("FAILED %0t vec_data got %h expected %h", $time,
			$sampled(vec_data), $sampled(head_data));
	end

	a_no_vec_while_stalled: assert property (@(posedge clock) disable iff (reset)
		vec_valid |-> run) else begin
		other_errors++;
		$display("Vector emission at %0t while run was low", $time);
	end

	// Count of term pulses still at the program's base, so none came before
	a_single_term: assert property (@(posedge clock) disable iff (reset)
		(term || vec_valid) |-> term_count == term_base) else begin
		other_errors++;
		$display("Activity at %0t after the program had already terminated", $time);
	end

	// Load, predict, start and wait for term
	task automatic run_program(input logic random_run);
		run = 1'b0;
		foreach (prog[i]) begin
			load_valid = 1'b1;
			load_word = prog[i];
			@(negedge clock);
		end
		load_valid = 1'b0;
		predict_program();
		term_base = term_count;
		start = 1'b1;
		started = 1'b1;
		@(negedge clock);
		start = 1'b0;
		while (term_count == term_base) begin
			run = random_run ? (($random(seed) & 3) != 0) : 1'b1;
			@(negedge clock);
		end
		run = 1'b1;
		repeat (8) @(negedge clock);
		assert (exp_words.size() == 0) else begin
			other_errors++;
			$display("%0d predicted vector emissions never appeared", exp_words.size());
		end
		assert (status == exp_status) else begin
			value_errors++;
			$display("FAILED %0t status got %b expected %b", $time, status, exp_status);
		end
	endtask

	initial begin
		reset = 1'b1;
		load_valid = 1'b0;
		load_word = '0;
		start = 1'b0;
		run = 1'b0;
		// Dependent LDI, ADD, SUB, AND, OR chain, then vector commands
		arith = '{16'h5105, 16'h5203, 16'h1312, 16'h2431, 16'h3543, 16'h4652,
			16'h2723, 16'hF070, 16'h8030, 16'h9040, 16'hA060, 16'h7000};
		// Taken zero branch, untaken zero branch, negative branch, jump;
		// the vector commands in the two slots after each taken one are dead
		flow = '{16'h5101, 16'h5201, 16'h2312, 16'h6107, 16'h8010, 16'h9020,
			16'h7000, 16'hB030, 16'h1412, 16'h6104, 16'h2531, 16'h620E,
			16'hC050, 16'hD050, 16'hE050, 16'h6012, 16'h8040, 16'h9040,
			16'hA040, 16'h7000};
		repeat (16) @(negedge clock);
		reset = 1'b0;
		repeat (4) @(negedge clock);
		prog = arith;
		run_program(1'b0);
		prog = flow;
		run_program(1'b0);
		run_program(1'b1);
		prog = arith;
		run_program(1'b1);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, errors: %0d value, %0d other",
			cycles, value_errors, other_errors);
		$display("TEST FAIL");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+.
isa_pkg.sv
core_pkg.sv
stage_if.sv
fetch_unit.sv
operand_read.sv
execute_unit.sv
scalar_core.sv
tb_scalar_core.sv
